//--- src/rpRegPkg.sv
// Register map, status and error bit positions and drive geometry for the disk drive model
package rpRegPkg;

   // Drive register addresses on the host register port
   localparam logic [4:0] REG_CS1 = 5'd0;
   localparam logic [4:0] REG_DA  = 5'd3;
   localparam logic [4:0] REG_DS  = 5'd5;
   localparam logic [4:0] REG_ER1 = 5'd6;
   localparam logic [4:0] REG_DC  = 5'd12;

   // Drive status bit positions
   localparam int DS_ATA = 15;
   localparam int DS_ERR = 14;
   localparam int DS_PIP = 13;
   localparam int DS_MOL = 12;
   localparam int DS_WRL = 11;
   localparam int DS_LST = 10;
   localparam int DS_PGM = 9;
   localparam int DS_DPR = 8;
   localparam int DS_DRY = 7;
   localparam int DS_VV  = 6;

   // Error register 1 bit positions
   localparam int ER1_ILF = 0;
   localparam int ER1_RMR = 2;
   localparam int ER1_IAE = 10;
   localparam int ER1_WLE = 11;

   // RP06 geometry, cylinders, tracks per cylinder, sectors per track
   localparam int NUM_CYL = 815;
   localparam int NUM_TRK = 19;
   localparam int NUM_SEC = 20;

endpackage

//--- src/rpFuncPkg.sv
// Drive function codes from CS1 and positioning timing shared by the function decoder and sequencer
package rpFuncPkg;

   ////////////////////////////////////////
   // Function codes, CS1 bits 5 to 1
   ////////////////////////////////////////

   typedef enum logic [4:0] {
      FN_NOP    = 5'd0,
      FN_SEEK   = 5'd2,
      FN_RECAL  = 5'd3,
      FN_DRVCLR = 5'd4,
      FN_PRESET = 5'd8,
      FN_PAKACK = 5'd9,
      FN_SEARCH = 5'd12,
      FN_WRITE  = 5'd24,
      FN_READ   = 5'd28
   } rpFuncT;

   ////////////////////////////////////////
   // Timing
   ////////////////////////////////////////

   // Fixed head positioning time in clocks
   localparam int SEEK_CYCLES = 16;

endpackage

//--- src/rpFunc.sv
// Function decoder, turns a CS1 write with GO into registered function and error pulses
`timescale 1ns/1ps

module rpFunc (
   input  logic        clk,
   input  logic        rst,
   input  logic [4:0]  regAddr,
   input  logic [15:0] regWrData,
   input  logic        regWrite,
   input  logic        dry,
   input  logic        addrBad,
   input  logic        writeProtect,
   output logic        fnSeek,
   output logic        fnXfer,
   output logic        fnDrvClr,
   output logic        fnPreset,
   output logic        fnPakAck,
   output logic        setIlf,
   output logic        setRmr,
   output logic        setIae,
   output logic        setWle
);
   import rpRegPkg::*;
   import rpFuncPkg::*;

   logic   goWrite;
   rpFuncT fnCode;
   logic   nSeek;
   logic   nXfer;
   logic   nDrvClr;
   logic   nPreset;
   logic   nPakAck;
   logic   nIlf;
   logic   nRmr;
   logic   nIae;
   logic   nWle;

   // GO bit is CS1 bit 0
   assign goWrite = regWrite && (regAddr == REG_CS1) && regWrData[0];
   assign fnCode  = rpFuncT'(regWrData[5:1]);

   ////////////////////////////////////////
   // Command decode
   ////////////////////////////////////////

   always_comb
   begin
      nSeek   = 1'b0;
      nXfer   = 1'b0;
      nDrvClr = 1'b0;
      nPreset = 1'b0;
      nPakAck = 1'b0;
      nIlf    = 1'b0;
      nRmr    = 1'b0;
      nIae    = 1'b0;
      nWle    = 1'b0;
      if (goWrite)
      begin
         // Drive clear goes through even while busy
         if (fnCode == FN_DRVCLR)
            nDrvClr = 1'b1;
         // Anything else while busy is refused
         else if (!dry)
            nRmr = 1'b1;
         else
         begin
            case (fnCode)
               FN_NOP:
                  nIlf = 1'b0;
               // Seek class, recal and search share the positioning path
               FN_SEEK, FN_RECAL, FN_SEARCH:
               begin
                  nIae  = addrBad;
                  nSeek = !addrBad;
               end
               FN_READ:
               begin
                  nIae  = addrBad;
                  nXfer = !addrBad;
               end
               // Write also checks the write lock, address error first
               FN_WRITE:
               begin
                  nIae  = addrBad;
                  nWle  = !addrBad && writeProtect;
                  nXfer = !addrBad && !writeProtect;
               end
               FN_PRESET:
                  nPreset = 1'b1;
               FN_PAKACK:
                  nPakAck = 1'b1;
               // Offset, release, unload, write check and unused codes
               default:
                  nIlf = 1'b1;
            endcase
         end
      end
   end

   ////////////////////////////////////////
   // Pulse registers
   ////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         fnSeek   <= 1'b0;
         fnXfer   <= 1'b0;
         fnDrvClr <= 1'b0;
         fnPreset <= 1'b0;
         fnPakAck <= 1'b0;
         setIlf   <= 1'b0;
         setRmr   <= 1'b0;
         setIae   <= 1'b0;
         setWle   <= 1'b0;
      end
      else
      begin
         fnSeek   <= nSeek;
         fnXfer   <= nXfer;
         fnDrvClr <= nDrvClr;
         fnPreset <= nPreset;
         fnPakAck <= nPakAck;
         setIlf   <= nIlf;
         setRmr   <= nRmr;
         setIae   <= nIae;
         setWle   <= nWle;
      end
   end

endmodule

//--- src/rpAddr.sv
// Disk address and desired cylinder registers with range check and per-sector advance
`timescale 1ns/1ps

module rpAddr (
   input  logic        clk,
   input  logic        rst,
   input  logic        clr,
   input  logic [4:0]  regAddr,
   input  logic [15:0] regWrData,
   input  logic        regWrite,
   input  logic        fnPreset,
   input  logic        sectorDone,
   input  logic        xferBusy,
   output logic [15:0] da,
   output logic [15:0] dc,
   output logic        addrBad,
   output logic        setLst,
   output logic        daWrite
);
   import rpRegPkg::*;

   logic [4:0] trk;
   logic [5:0] sec;
   logic [9:0] cyl;
   logic       dcWrite;
   logic       advance;
   logic       lastSec;
   logic       lastTrk;

   // Host write strobes
   assign daWrite = regWrite && (regAddr == REG_DA);
   assign dcWrite = regWrite && (regAddr == REG_DC);

   // Sector done only counts during a transfer
   assign advance = sectorDone && xferBusy;
   assign lastSec = (sec == 6'(NUM_SEC - 1));
   assign lastTrk = (trk == 5'(NUM_TRK - 1));

   // Wrap from last sector of last track, LST sets on the same edge
   assign setLst = advance && lastSec && lastTrk;

   // Any field at or past its limit
   assign addrBad = (cyl >= 10'(NUM_CYL)) || (trk >= 5'(NUM_TRK)) || (sec >= 6'(NUM_SEC));

   // Track in 12:8, sector in 5:0
   assign da = {3'b000, trk, 2'b00, sec};
   assign dc = {6'b000000, cyl};

   ////////////////////////////////////////
   // Track and sector
   ////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         trk <= '0;
         sec <= '0;
      end
      else if (clr || fnPreset)
      begin
         trk <= '0;
         sec <= '0;
      end
      // Host write wins over an advance
      else if (daWrite)
      begin
         trk <= regWrData[12:8];
         sec <= regWrData[5:0];
      end
      else if (advance)
      begin
         if (lastSec)
         begin
            sec <= '0;
            trk <= lastTrk ? 5'd0 : trk + 5'd1;
         end
         else
            sec <= sec + 6'd1;
      end
   end

   ////////////////////////////////////////
   // Cylinder
   ////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         cyl <= '0;
      else if (clr || fnPreset)
         cyl <= '0;
      else if (dcWrite)
         cyl <= regWrData[9:0];
      // Carry out of the track field
      else if (setLst)
         cyl <= cyl + 10'd1;
   end

endmodule

//--- src/rpPosition.sv
// Positioning and transfer sequencer, drives PIP, drive ready and the set-attention pulse
`timescale 1ns/1ps

module rpPosition (
   input  logic clk,
   input  logic rst,
   input  logic clr,
   input  logic fnSeek,
   input  logic fnXfer,
   input  logic fnDrvClr,
   input  logic sectorDone,
   output logic pip,
   output logic dry,
   output logic xferBusy,
   output logic setAta
);
   import rpFuncPkg::*;

   localparam int CNT_W = $clog2(SEEK_CYCLES + 1);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_SEEK,
      ST_XFER
   } posStateT;

   posStateT         state;
   logic [CNT_W-1:0] cnt;
   logic             seekDone;

   // Last positioning cycle
   assign seekDone = (state == ST_SEEK) && (cnt == CNT_W'(1));

   assign pip      = (state == ST_SEEK);
   assign xferBusy = (state == ST_XFER);
   assign dry      = (state == ST_IDLE);

   ////////////////////////////////////////
   // Sequencer FSM
   ////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state  <= ST_IDLE;
         cnt    <= '0;
         setAta <= 1'b0;
      end
      else
      begin
         setAta <= 1'b0;
         // Abort back to idle, no attention
         if (clr || fnDrvClr)
            state <= ST_IDLE;
         else
         begin
            case (state)
               ST_IDLE:
                  if (fnSeek)
                  begin
                     state <= ST_SEEK;
                     cnt   <= CNT_W'(SEEK_CYCLES);
                  end
                  else if (fnXfer)
                     state <= ST_XFER;
               ST_SEEK:
                  if (seekDone)
                  begin
                     state  <= ST_IDLE;
                     setAta <= 1'b1;
                  end
                  else
                     cnt <= cnt - CNT_W'(1);
               // Held busy until the sector finishes
               ST_XFER:
                  if (sectorDone)
                     state <= ST_IDLE;
               default:
                  state <= ST_IDLE;
            endcase
         end
      end
   end

endmodule

//--- src/rpEr1.sv
// Error register 1, host loadable, with error set pulses and drive clear
`timescale 1ns/1ps

module rpEr1 (
   input  logic        clk,
   input  logic        rst,
   input  logic        clr,
   input  logic [4:0]  regAddr,
   input  logic [15:0] regWrData,
   input  logic        regWrite,
   input  logic        fnDrvClr,
   input  logic        setIlf,
   input  logic        setRmr,
   input  logic        setIae,
   input  logic        setWle,
   output logic [15:0] er1
);
   import rpRegPkg::*;

   logic        er1Write;
   logic [15:0] setBits;
   logic [15:0] loadVal;

   assign er1Write = regWrite && (regAddr == REG_ER1);

   // Error bits raised by the function decoder
   always_comb
   begin
      setBits          = '0;
      setBits[ER1_ILF] = setIlf;
      setBits[ER1_RMR] = setRmr;
      setBits[ER1_IAE] = setIae;
      setBits[ER1_WLE] = setWle;
   end

   // Set bits ORed over the load so a set wins
   assign loadVal = (er1Write ? regWrData : er1) | setBits;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         er1 <= '0;
      else if (clr || fnDrvClr)
         er1 <= '0;
      else
         er1 <= loadVal;
   end

endmodule

//--- src/rpDs.sv
// Drive status register, attention, last sector and volume valid flags plus level bits
`timescale 1ns/1ps

module rpDs (
   input  logic        clk,
   input  logic        rst,
   input  logic        clr,
   input  logic        mol,
   input  logic        ataClr,
   input  logic        setLst,
   input  logic        setAta,
   input  logic        cardDetect,
   input  logic        writeProtect,
   input  logic        pip,
   input  logic        dry,
   input  logic        fnDrvClr,
   input  logic        fnPreset,
   input  logic        fnPakAck,
   input  logic        daWrite,
   input  logic [15:0] er1,
   output logic [15:0] ds
);
   import rpRegPkg::*;

   logic dsAta;
   logic dsLst;
   logic dsVv;

   ////////////////////////////////////////
   // Attention
   ////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         dsAta <= 1'b0;
      else if (clr || ataClr || fnDrvClr)
         dsAta <= 1'b0;
      else if (setAta)
         dsAta <= 1'b1;
   end

   ////////////////////////////////////////
   // Last sector transferred
   ////////////////////////////////////////

   // A new DA from the host drops it
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         dsLst <= 1'b0;
      else if (clr || daWrite)
         dsLst <= 1'b0;
      else if (setLst)
         dsLst <= 1'b1;
   end

   ////////////////////////////////////////
   // Volume valid
   ////////////////////////////////////////

   // Lost as soon as the card is pulled
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         dsVv <= 1'b0;
      else if (clr || !cardDetect)
         dsVv <= 1'b0;
      else if (fnPreset || fnPakAck)
         dsVv <= 1'b1;
   end

   // Register assembly
   always_comb
   begin
      ds         = '0;
      ds[DS_ATA] = dsAta;
      ds[DS_ERR] = |er1;        // composite error, ER1 only
      ds[DS_PIP] = pip;
      ds[DS_MOL] = mol;
      ds[DS_WRL] = writeProtect;
      ds[DS_LST] = dsLst;
      ds[DS_PGM] = 1'b0;
      ds[DS_DPR] = 1'b1;
      ds[DS_DRY] = dry;
      ds[DS_VV]  = dsVv;
   end

endmodule

//--- src/rpDrive.sv
// Drive top level, connects the register blocks and multiplexes register reads
`timescale 1ns/1ps

module rpDrive (
   input  logic        clk,
   input  logic        rst,
   input  logic [4:0]  regAddr,
   input  logic [15:0] regWrData,
   input  logic        regWrite,
   output logic [15:0] regRdData,
   input  logic        clr,
   input  logic        ataClr,
   input  logic        sectorDone,
   input  logic        mol,
   input  logic        cardDetect,
   input  logic        writeProtect
);
   import rpRegPkg::*;

   logic        fnSeek;
   logic        fnXfer;
   logic        fnDrvClr;
   logic        fnPreset;
   logic        fnPakAck;
   logic        setIlf;
   logic        setRmr;
   logic        setIae;
   logic        setWle;
   logic        addrBad;
   logic        setLst;
   logic        daWrite;
   logic        pip;
   logic        dry;
   logic        xferBusy;
   logic        setAta;
   logic [15:0] da;
   logic [15:0] dc;
   logic [15:0] er1;
   logic [15:0] ds;
   logic [4:0]  cs1Fn;

   // Last function code written to CS1, for readback
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         cs1Fn <= '0;
      else if (regWrite && (regAddr == REG_CS1))
         cs1Fn <= regWrData[5:1];
   end

   ////////////////////////////////////////
   // Blocks
   ////////////////////////////////////////

   rpFunc i_rpFunc (
      .clk(clk), .rst(rst), .regAddr(regAddr), .regWrData(regWrData),
      .regWrite(regWrite), .dry(dry), .addrBad(addrBad),
      .writeProtect(writeProtect), .fnSeek(fnSeek), .fnXfer(fnXfer),
      .fnDrvClr(fnDrvClr), .fnPreset(fnPreset), .fnPakAck(fnPakAck),
      .setIlf(setIlf), .setRmr(setRmr), .setIae(setIae), .setWle(setWle)
   );

   rpAddr i_rpAddr (
      .clk(clk), .rst(rst), .clr(clr), .regAddr(regAddr),
      .regWrData(regWrData), .regWrite(regWrite), .fnPreset(fnPreset),
      .sectorDone(sectorDone), .xferBusy(xferBusy), .da(da), .dc(dc),
      .addrBad(addrBad), .setLst(setLst), .daWrite(daWrite)
   );

   rpPosition i_rpPosition (
      .clk(clk), .rst(rst), .clr(clr), .fnSeek(fnSeek), .fnXfer(fnXfer),
      .fnDrvClr(fnDrvClr), .sectorDone(sectorDone), .pip(pip), .dry(dry),
      .xferBusy(xferBusy), .setAta(setAta)
   );

   rpEr1 i_rpEr1 (
      .clk(clk), .rst(rst), .clr(clr), .regAddr(regAddr),
      .regWrData(regWrData), .regWrite(regWrite), .fnDrvClr(fnDrvClr),
      .setIlf(setIlf), .setRmr(setRmr), .setIae(setIae), .setWle(setWle),
      .er1(er1)
   );

   rpDs i_rpDs (
      .clk(clk), .rst(rst), .clr(clr), .mol(mol), .ataClr(ataClr),
      .setLst(setLst), .setAta(setAta), .cardDetect(cardDetect),
      .writeProtect(writeProtect), .pip(pip), .dry(dry),
      .fnDrvClr(fnDrvClr), .fnPreset(fnPreset), .fnPakAck(fnPakAck),
      .daWrite(daWrite), .er1(er1), .ds(ds)
   );

   ////////////////////////////////////////
   // Read multiplexer
   ////////////////////////////////////////

   always_comb
   begin
      case (regAddr)
         // Ready in bit 7, function in 5:1, GO reads zero
         REG_CS1: regRdData = {8'h00, dry, 1'b0, cs1Fn, 1'b0};
         REG_DA:  regRdData = da;
         REG_DC:  regRdData = dc;
         REG_DS:  regRdData = ds;
         REG_ER1: regRdData = er1;
         default: regRdData = '0;
      endcase
   end

endmodule

//--- test/rpDrive_sva.sv
// Assertions bound into the drive top level, checks ready, attention and composite error
`timescale 1ns/1ps

module rpDriveSva (
   input logic        clk,
   input logic        rst,
   input logic        clr,
   input logic        ataClr,
   input logic        fnDrvClr,
   input logic        pip,
   input logic        dry,
   input logic        setAta,
   input logic [15:0] ds,
   input logic [15:0] er1
);
   import rpRegPkg::*;

   // Positioning and ready never overlap
   pipDryExcl: assert property (@(posedge clk) disable iff (rst) !(pip && dry))
      else $error("pip and dry are high in the same cycle");

   // Attention lands one edge after the set pulse unless cleared
   ataFollows: assert property (@(posedge clk) disable iff (rst)
      (setAta && !clr && !ataClr && !fnDrvClr) |=> ds[DS_ATA])
      else $error("attention did not set after setAta");

   // Composite error is the OR of ER1
   errMatch: assert property (@(posedge clk) disable iff (rst) ds[DS_ERR] == (|er1))
      else $error("composite error does not follow ER1");

endmodule

//--- test/rpDriveTb.sv
// Random register traffic testbench for the drive model, reads are checked against a cycle model
`timescale 1ns/1ps

module rpDriveTb;
   import rpRegPkg::*;
   import rpFuncPkg::*;

   localparam int NUM_OPS = 400;
   localparam int ST_IDLE = 0;
   localparam int ST_SEEK = 1;
   localparam int ST_XFER = 2;

   logic        clk;
   logic        rst;
   logic [4:0]  regAddr;
   logic [15:0] regWrData;
   logic        regWrite;
   logic [15:0] regRdData;
   logic        clr;
   logic        ataClr;
   logic        sectorDone;
   logic        mol;
   logic        cardDetect;
   logic        writeProtect;
   int          errorCount;

   // Model registers, address fields kept as plain integers
   int          mTrk;
   int          mSec;
   int          mCyl;
   int          mState;
   int          mCnt;
   logic [15:0] mEr1;
   logic [4:0]  mFn;
   logic        mAta;
   logic        mLst;
   logic        mVv;
   // Model of the registered pulses between blocks
   logic        pSeek;
   logic        pXfer;
   logic        pDrvClr;
   logic        pPreset;
   logic        pPakAck;
   logic        pSetAta;
   logic [15:0] pErr;

   logic [4:0]  validFn [9] = '{FN_NOP, FN_SEEK, FN_RECAL, FN_DRVCLR, FN_PRESET,
                                FN_PAKACK, FN_SEARCH, FN_WRITE, FN_READ};
   logic [4:0]  readRegs [5] = '{REG_CS1, REG_DA, REG_DS, REG_ER1, REG_DC};

   rpDrive i_rpDrive (
      .clk(clk), .rst(rst), .regAddr(regAddr), .regWrData(regWrData),
      .regWrite(regWrite), .regRdData(regRdData), .clr(clr), .ataClr(ataClr),
      .sectorDone(sectorDone), .mol(mol), .cardDetect(cardDetect),
      .writeProtect(writeProtect)
   );

   bind rpDrive rpDriveSva i_rpDriveSva (
      .clk(clk), .rst(rst), .clr(clr), .ataClr(ataClr), .fnDrvClr(fnDrvClr),
      .pip(pip), .dry(dry), .setAta(setAta), .ds(ds), .er1(er1)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////

   // Expected read data for one register address
   function automatic logic [15:0] expRead(input logic [4:0] addr);
      logic [15:0] ds;
      ds         = '0;
      ds[DS_ATA] = mAta;
      ds[DS_ERR] = |mEr1;
      ds[DS_PIP] = (mState == ST_SEEK);
      ds[DS_MOL] = mol;
      ds[DS_WRL] = writeProtect;
      ds[DS_LST] = mLst;
      ds[DS_DPR] = 1'b1;
      ds[DS_DRY] = (mState == ST_IDLE);
      ds[DS_VV]  = mVv;
      case (addr)
         REG_CS1: return {8'h00, (mState == ST_IDLE), 1'b0, mFn, 1'b0};
         REG_DA:  return {3'b000, 5'(mTrk), 2'b00, 6'(mSec)};
         REG_DC:  return {6'b000000, 10'(mCyl)};
         REG_DS:  return ds;
         REG_ER1: return mEr1;
         default: return '0;
      endcase
   endfunction

   // One clock, inputs were driven at the falling edge, model follows the rising edge
   task automatic step;
      logic        go;
      logic        bad;
      logic        adv;
      logic        lastWrap;
      logic [4:0]  code;
      logic        nSeek;
      logic        nXfer;
      logic        nDrvClr;
      logic        nPreset;
      logic        nPakAck;
      logic [15:0] nErr;
      bad     = (mCyl >= NUM_CYL) || (mTrk >= NUM_TRK) || (mSec >= NUM_SEC);
      go      = regWrite && (regAddr == REG_CS1) && regWrData[0];
      code    = regWrData[5:1];
      nSeek   = 1'b0;
      nXfer   = 1'b0;
      nDrvClr = 1'b0;
      nPreset = 1'b0;
      nPakAck = 1'b0;
      nErr    = '0;
      if (go)
      begin
         if (code == FN_DRVCLR)
            nDrvClr = 1'b1;
         // Busy drive refuses everything but drive clear
         else if (mState != ST_IDLE)
            nErr[ER1_RMR] = 1'b1;
         else
         begin
            case (code)
               FN_NOP: ;
               FN_SEEK, FN_RECAL, FN_SEARCH:
               begin
                  nErr[ER1_IAE] = bad;
                  nSeek         = !bad;
               end
               FN_READ:
               begin
                  nErr[ER1_IAE] = bad;
                  nXfer         = !bad;
               end
               FN_WRITE:
               begin
                  nErr[ER1_IAE] = bad;
                  nErr[ER1_WLE] = !bad && writeProtect;
                  nXfer         = !bad && !writeProtect;
               end
               FN_PRESET: nPreset = 1'b1;
               FN_PAKACK: nPakAck = 1'b1;
               default:   nErr[ER1_ILF] = 1'b1;
            endcase
         end
      end
      @(posedge clk);
      adv      = sectorDone && (mState == ST_XFER);
      lastWrap = adv && (mSec == NUM_SEC - 1) && (mTrk == NUM_TRK - 1);
      // Address fields wrap at their bit widths
      if (clr || pPreset)
      begin
         mTrk = 0;
         mSec = 0;
         mCyl = 0;
      end
      else
      begin
         if (regWrite && (regAddr == REG_DA))
         begin
            mTrk = int'(regWrData[12:8]);
            mSec = int'(regWrData[5:0]);
         end
         else if (adv && (mSec == NUM_SEC - 1))
         begin
            mSec = 0;
            mTrk = (mTrk == NUM_TRK - 1) ? 0 : (mTrk + 1) % 32;
         end
         else if (adv)
            mSec = (mSec + 1) % 64;
         if (regWrite && (regAddr == REG_DC))
            mCyl = int'(regWrData[9:0]);
         else if (lastWrap)
            mCyl = (mCyl + 1) % 1024;
      end
      if (clr || pDrvClr)
         mEr1 = '0;
      else
         mEr1 = ((regWrite && (regAddr == REG_ER1)) ? regWrData : mEr1) | pErr;
      if (clr || ataClr || pDrvClr)
         mAta = 1'b0;
      else if (pSetAta)
         mAta = 1'b1;
      pSetAta = 1'b0;
      // Positioning counter and ready
      if (clr || pDrvClr)
         mState = ST_IDLE;
      else if (mState == ST_IDLE)
      begin
         if (pSeek)
         begin
            mState = ST_SEEK;
            mCnt   = SEEK_CYCLES;
         end
         else if (pXfer)
            mState = ST_XFER;
      end
      else if (mState == ST_SEEK)
      begin
         if (mCnt == 1)
         begin
            mState  = ST_IDLE;
            pSetAta = 1'b1;
         end
         else
            mCnt = mCnt - 1;
      end
      else if (sectorDone)
         mState = ST_IDLE;
      if (clr || (regWrite && (regAddr == REG_DA)))
         mLst = 1'b0;
      else if (lastWrap)
         mLst = 1'b1;
      if (clr || !cardDetect)
         mVv = 1'b0;
      else if (pPreset || pPakAck)
         mVv = 1'b1;
      if (regWrite && (regAddr == REG_CS1))
         mFn = regWrData[5:1];
      pSeek   = nSeek;
      pXfer   = nXfer;
      pDrvClr = nDrvClr;
      pPreset = nPreset;
      pPakAck = nPakAck;
      pErr    = nErr;
      @(negedge clk);
   endtask

   ////////////////////////////////////////
   // Checks and stimulus
   ////////////////////////////////////////

   task automatic checkValue(input logic [15:0] got, input logic [15:0] exp, input string what);
      if (got !== exp)
      begin
         errorCount++;
         $display("ERROR at %0t: %s reads %h, expected %h", $time, what, got, exp);
         $display("Errors found");
         $fatal(1, "register readback mismatch");
      end
   endtask

   task automatic readCheck(input logic [4:0] addr);
      regAddr = addr;
      #1;
      checkValue(regRdData, expRead(addr), $sformatf("register %0d", addr));
   endtask

   // Register write, weighted toward supported functions and in-range addresses
   task automatic randomWrite;
      logic [31:0] r;
      logic [31:0] d;
      logic [4:0]  code;
      int          sel;
      int          idx;
      r         = $urandom;
      d         = $urandom;
      sel       = int'(r[7:0]) % 10;
      idx       = int'(r[19:12]) % 9;
      regWrite  = 1'b1;
      regWrData = d[15:0];
      if (sel < 5)
      begin
         regAddr   = REG_CS1;
         code      = (r[8] || r[9]) ? validFn[idx] : d[5:1];
         regWrData = {d[15:6], code, r[10] | r[11]};
      end
      else if (sel < 7)
      begin
         regAddr = REG_DA;
         // Park near the end of the last track now and then
         if (r[20] && r[21])
            regWrData = {3'b000, 5'd18, 2'b00, r[22] ? 6'd19 : 6'd18};
         else if (!r[23])
            regWrData = {3'b000, 5'(d[7:0] % 19), 2'b00, 6'(d[15:8] % 20)};
      end
      else if (sel < 8)
      begin
         regAddr = REG_DC;
         if (!r[24])
            regWrData = {6'b000000, 10'(d[15:0] % 815)};
      end
      else if (sel < 9)
         regAddr = REG_ER1;
      else
         regAddr = r[31:27];
      step();
      regWrite = 1'b0;
   endtask

   // Watch DS while idling, then read back a random register
   task automatic idleAndRead;
      logic [31:0] r;
      int          n;
      r = $urandom;
      n = int'(r[3:0]) % 12;
      repeat (n)
      begin
         readCheck(REG_DS);
         step();
      end
      readCheck(REG_ER1);
      readCheck(readRegs[int'(r[7:4]) % 5]);
      step();
   endtask

   initial
   begin
      repeat (NUM_OPS * (SEEK_CYCLES + 4)) @(posedge clk);
      $display("Timeout, the random traffic did not finish before the watchdog expired");
      $display("Errors found");
      $fatal(1, "watchdog timeout");
   end

   initial
   begin
      logic [31:0] r;
      int          kind;
      r            = $urandom(78);
      rst          = 1'b1;
      regAddr      = '0;
      regWrData    = '0;
      regWrite     = 1'b0;
      clr          = 1'b0;
      ataClr       = 1'b0;
      sectorDone   = 1'b0;
      mol          = 1'b1;
      cardDetect   = 1'b1;
      writeProtect = 1'b0;
      errorCount   = 0;
      mTrk         = 0;
      mSec         = 0;
      mCyl         = 0;
      mState       = ST_IDLE;
      mCnt         = 0;
      mEr1         = '0;
      mFn          = '0;
      mAta         = 1'b0;
      mLst         = 1'b0;
      mVv          = 1'b0;
      pSeek        = 1'b0;
      pXfer        = 1'b0;
      pDrvClr      = 1'b0;
      pPreset      = 1'b0;
      pPakAck      = 1'b0;
      pSetAta      = 1'b0;
      pErr         = '0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      for (int op = 0; op < NUM_OPS; op++)
      begin
         r    = $urandom;
         kind = int'(r[7:0]) % 100;
         if (kind < 40)
            randomWrite();
         else if (kind < 65)
            idleAndRead();
         else if (kind < 80)
         begin
            sectorDone = 1'b1;
            step();
            sectorDone = 1'b0;
         end
         else if (kind < 88)
         begin
            // Level inputs, one of three
            if (r[9:8] == 2'd0)
               writeProtect = ~writeProtect;
            else if (r[9:8] == 2'd1)
               mol = ~mol;
            else
               cardDetect = ~cardDetect;
            step();
         end
         else if (kind < 96)
         begin
            ataClr = 1'b1;
            step();
            ataClr = 1'b0;
         end
         else
         begin
            clr = 1'b1;
            step();
            clr = 1'b0;
         end
      end
      if (errorCount == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

//--- sources.f
src/rpRegPkg.sv
src/rpFuncPkg.sv
src/rpFunc.sv
src/rpAddr.sv
src/rpPosition.sv
src/rpEr1.sv
src/rpDs.sv
src/rpDrive.sv
test/rpDrive_sva.sv
test/rpDriveTb.sv

//--- Makefile
# Verilator lint, simulation and clean for the drive testbench
VERILATOR ?= verilator
TOP       ?= rpDriveTb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# The run log decides pass or fail
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
